// File: hw/panel_pkg.sv
/*
 * status panel package
 * shared types, privilege codes, seven-segment glyphs, anode patterns and RGB codes
 */
package panel_pkg;

    // privilege level as reported by the core, code 2 is reserved
    typedef logic [1:0] priv_t;
    localparam priv_t PRIV_U = 2'd0;
    localparam priv_t PRIV_S = 2'd1;
    localparam priv_t PRIV_M = 2'd3;

    typedef struct packed {
        logic  init_done;
        logic  loading;
        priv_t priv;
    } panel_status_t;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic center;
    } buttons_t;

    // keyboard or mouse byte, valid is a one-cycle strobe
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_event_t;

    localparam int NUM_DIGITS = 8;
    localparam int DISP_W     = 32;
    localparam int SEG_W      = 8;  // bit 7 is the decimal point

    typedef logic [SEG_W-1:0] glyph_t;

    // letter glyphs, active high, segment a in bit 6
    localparam glyph_t SEG_UA = 8'b0111_0111;  // A
    localparam glyph_t SEG_UP = 8'b0110_0111;  // P
    localparam glyph_t SEG_UL = 8'b0000_1110;  // L
    localparam glyph_t SEG_R  = 8'b0000_0101;
    localparam glyph_t SEG_C  = 8'b0000_1101;
    localparam glyph_t SEG_H  = 8'b0001_0111;
    localparam glyph_t SEG_O  = 8'b0001_1101;
    localparam glyph_t SEG_A  = 8'b0111_1101;
    localparam glyph_t SEG_D  = 8'b0011_1101;
    localparam glyph_t SEG_I  = 8'b0001_0000;
    localparam glyph_t SEG_N  = 8'b0001_0101;
    localparam glyph_t SEG_G  = 8'b1111_1011;  // g carries the dot
    localparam glyph_t SEG_DP = 8'b1000_0000;

    localparam glyph_t HEX_GLYPHS [16] = '{
        8'h7e, 8'h30, 8'h6d, 8'h79, 8'h33, 8'h5b, 8'h5f, 8'h70,
        8'h7f, 8'h7b, 8'h77, 8'h1f, 8'h4e, 8'h3d, 8'h4f, 8'h47
    };

    // "ArchProc", index 0 is the rightmost digit
    localparam glyph_t BANNER_GLYPHS [NUM_DIGITS] = '{
        SEG_C, SEG_O, SEG_R, SEG_UP, SEG_H, SEG_C, SEG_R, SEG_UA
    };

    // blank lead-in, "Loading", then two dots
    localparam glyph_t LOAD_GLYPHS [16] = '{
        8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
        SEG_UL, SEG_O, SEG_A, SEG_D, SEG_I, SEG_N, SEG_G,
        SEG_DP, SEG_DP
    };

    // common anodes are active low, one per digit
    localparam logic [NUM_DIGITS-1:0] AN_PATTERNS [NUM_DIGITS] = '{
        8'hfe, 8'hfd, 8'hfb, 8'hf7, 8'hef, 8'hdf, 8'hbf, 8'h7f
    };

    // rgb bus order is {blue, green, red}
    localparam logic [2:0] RGB_OFF   = 3'b000;
    localparam logic [2:0] RGB_BLUE  = 3'b100;
    localparam logic [2:0] RGB_GREEN = 3'b010;
    localparam logic [2:0] RGB_RED   = 3'b001;

endpackage

// File: hw/status_capture.sv
/*
 * status capture
 * heartbeat, keyboard and mouse byte history, display value select, status LEDs
 */
`timescale 1ns/1ps

module status_capture #(
    parameter int HEARTBEAT_HALF = 32000000
) (
    input  logic                        CORE_CLK,
    input  logic                        CORE_RST_X,
    input  panel_pkg::panel_status_t    i_status,
    input  panel_pkg::buttons_t         i_buttons,
    input  panel_pkg::byte_event_t      i_kbd,
    input  panel_pkg::byte_event_t      i_mouse,
    input  logic [31:0]                 i_core_pc,
    input  logic [31:0]                 i_core_ir,
    output logic [panel_pkg::DISP_W-1:0] o_disp,
    output logic [15:0]                 o_led
);
    import panel_pkg::*;

    localparam int HB_W = $clog2(HEARTBEAT_HALF + 1);

    logic [HB_W-1:0] r_hb_cnt;
    logic            r_heartbeat;

    // [15:8] older byte, [7:0] latest byte
    logic [15:0]       r_kbd_hist;
    logic [15:0]       r_mouse_hist;
    logic [DISP_W-1:0] w_hist;

    // heartbeat half period
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            r_hb_cnt    <= '0;
            r_heartbeat <= 1'b0;
        end else if (r_hb_cnt == HB_W'(HEARTBEAT_HALF - 1)) begin
            r_hb_cnt    <= '0;
            r_heartbeat <= ~r_heartbeat;
        end else begin
            r_hb_cnt <= r_hb_cnt + 1'b1;
        end
    end

    // byte strobes cannot be refused, take them as they come
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            r_kbd_hist   <= '0;
            r_mouse_hist <= '0;
        end else begin
            if (i_kbd.valid)
                r_kbd_hist <= {r_kbd_hist[7:0], i_kbd.data};       // shift older out
            if (i_mouse.valid)
                r_mouse_hist <= {r_mouse_hist[7:0], i_mouse.data};
        end
    end

    assign w_hist = {r_mouse_hist, r_kbd_hist};

    // up, down and center blank the value; left and right pick core state
    always_comb begin
        if (i_buttons.up || i_buttons.down || i_buttons.center)
            o_disp = '0;
        else if (i_buttons.left)
            o_disp = i_core_pc;
        else if (i_buttons.right)
            o_disp = i_core_ir;
        else
            o_disp = w_hist;  // idle shows input history
    end

    assign o_led = {13'd0, i_status.loading, i_status.init_done, r_heartbeat};

endmodule

// File: hw/seg7_scanner.sv
/*
 * seven-segment scanner
 * multiplexes eight digits showing hex, a startup banner or the loading animation
 */
`timescale 1ns/1ps

module seg7_scanner #(
    parameter int SCAN_DIV       = 16000,
    parameter int LOAD_STEP_BITS = 25
) (
    input  logic                             CORE_CLK,
    input  logic                             CORE_RST_X,
    input  panel_pkg::panel_status_t         i_status,
    input  logic [panel_pkg::DISP_W-1:0]     i_disp,
    output logic [panel_pkg::SEG_W-1:0]      o_sg,
    output logic [panel_pkg::NUM_DIGITS-1:0] o_an
);
    import panel_pkg::*;

    localparam int SCAN_W = $clog2(SCAN_DIV + 1);
    localparam int DIG_W  = $clog2(NUM_DIGITS);

    // display value split into digit nibbles
    logic [NUM_DIGITS-1:0][3:0] r_val;

    logic [SCAN_W-1:0] r_scan_cnt;
    logic              w_step;
    logic [DIG_W-1:0]  r_digit;

    logic [LOAD_STEP_BITS-1:0] r_load_cnt;
    logic [3:0]                r_load_step;
    logic [3:0]                w_load_idx;

    glyph_t w_glyph;

    always_ff @(posedge CORE_CLK) begin
        r_val <= i_disp;
    end

    // scan divider, a step fires on count zero
    assign w_step = (r_scan_cnt == '0);

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X)
            r_scan_cnt <= '0;
        else if (r_scan_cnt == SCAN_W'(SCAN_DIV - 1))
            r_scan_cnt <= '0;
        else
            r_scan_cnt <= r_scan_cnt + 1'b1;
    end

    // animation timebase, frozen outside loading
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            r_load_cnt  <= '0;
            r_load_step <= '0;
        end else if (i_status.loading) begin
            r_load_cnt <= r_load_cnt + 1'b1;
            if (&r_load_cnt)
                r_load_step <= r_load_step + 4'd1;  // advance on wrap
        end
    end

    // text slides leftward as the step grows, wraps mod 16
    assign w_load_idx = r_load_step + 4'd7 - 4'(r_digit);

    always_comb begin
        if (i_status.loading)
            w_glyph = LOAD_GLYPHS[w_load_idx];
        else if (i_status.init_done)
            w_glyph = HEX_GLYPHS[r_val[r_digit]];
        else
            w_glyph = BANNER_GLYPHS[r_digit];
    end

    /*
     * anode and cathode are loaded in the same cycle so the
     * segments never show a neighbouring digit's glyph
     */
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            r_digit <= '0;
            o_an    <= '1;  // all digits dark
            o_sg    <= '1;
        end else if (w_step) begin
            r_digit <= r_digit + 1'b1;
            o_an    <= AN_PATTERNS[r_digit];
            o_sg    <= ~w_glyph;  // segments active low
        end
    end

endmodule

// File: hw/rgb_breather.sv
/*
 * RGB LED driver
 * breathing pattern while loading, privilege colour blink once running
 */
`timescale 1ns/1ps

module rgb_breather #(
    parameter int PWM_BITS = 12
) (
    input  logic                     CORE_CLK,
    input  logic                     CORE_RST_X,
    input  panel_pkg::panel_status_t i_status,
    output logic [2:0]               o_rgb
);
    import panel_pkg::*;

    localparam int PH_W = PWM_BITS + 1;

    logic [PWM_BITS-1:0] r_pwm_cnt;
    logic                w_pwm_wrap;
    logic [3:0]          r_blink_cnt;
    logic [2:0]          w_breath;
    logic [2:0]          w_priv_rgb;

    assign w_pwm_wrap = &r_pwm_cnt;

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            r_pwm_cnt   <= '0;
            r_blink_cnt <= '0;
        end else begin
            r_pwm_cnt   <= r_pwm_cnt + 1'b1;
            r_blink_cnt <= r_blink_cnt + 4'd1;
        end
    end

    // ch 2 blue, 1 green, 0 red; different rates keep the colours drifting
    for (genvar ch = 0; ch < 3; ch++) begin : g_chan
        localparam int OFFSET = (ch == 2) ? 0 :
                                (ch == 1) ? (1 << (PWM_BITS - 6)) : (1 << (PWM_BITS - 3));
        localparam int INC    = (ch == 2) ? 2 : (ch == 1) ? 3 : 5;

        logic [PH_W-1:0] r_phase;

        always_ff @(posedge CORE_CLK) begin
            if (!CORE_RST_X)
                r_phase <= PH_W'(OFFSET);
            else if (w_pwm_wrap)
                r_phase <= r_phase + PH_W'(INC);
        end

        // top bit flips the compare so duty ramps up then back down
        assign w_breath[ch] = r_phase[PWM_BITS] ? (r_phase[PWM_BITS-1:0] < r_pwm_cnt)
                                                : (r_phase[PWM_BITS-1:0] >= r_pwm_cnt);
    end

    always_comb begin
        case (i_status.priv)
            PRIV_U:  w_priv_rgb = RGB_BLUE;
            PRIV_S:  w_priv_rgb = RGB_GREEN;
            PRIV_M:  w_priv_rgb = RGB_RED;
            default: w_priv_rgb = RGB_OFF;  // reserved code
        endcase
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X)
            o_rgb <= RGB_OFF;
        else if (i_status.loading)
            o_rgb <= w_breath;
        else if (!i_status.init_done)
            o_rgb <= RGB_OFF;
        else
            o_rgb <= (r_blink_cnt == 4'd0) ? w_priv_rgb : RGB_OFF;  // short flash
    end

endmodule

// File: hw/status_panel_top.sv
/*
 * status panel top
 * board LEDs, seven-segment display and RGB LED for the SoC
 */
`timescale 1ns/1ps

module status_panel_top #(
    parameter int HEARTBEAT_HALF = 32000000,
    parameter int SCAN_DIV       = 16000,
    parameter int LOAD_STEP_BITS = 25,
    parameter int PWM_BITS       = 12
) (
    input  logic                     CORE_CLK,
    input  logic                     CORE_RST_X,
    input  panel_pkg::panel_status_t i_status,
    input  panel_pkg::buttons_t      i_buttons,
    input  panel_pkg::byte_event_t   i_kbd,
    input  panel_pkg::byte_event_t   i_mouse,
    input  logic [31:0]              i_core_pc,
    input  logic [31:0]              i_core_ir,
    output logic [15:0]              o_led,
    output logic [7:0]               o_sg,
    output logic [7:0]               o_an,
    output logic [2:0]               o_rgb
);
    import panel_pkg::*;

    logic [DISP_W-1:0] w_disp;  // selected value for the display

    status_capture #(
        .HEARTBEAT_HALF (HEARTBEAT_HALF)
    ) u_status_capture (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .i_status   (i_status),
        .i_buttons  (i_buttons),
        .i_kbd      (i_kbd),
        .i_mouse    (i_mouse),
        .i_core_pc  (i_core_pc),
        .i_core_ir  (i_core_ir),
        .o_disp     (w_disp),
        .o_led      (o_led)
    );

    seg7_scanner #(
        .SCAN_DIV       (SCAN_DIV),
        .LOAD_STEP_BITS (LOAD_STEP_BITS)
    ) u_seg7_scanner (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .i_status   (i_status),
        .i_disp     (w_disp),
        .o_sg       (o_sg),
        .o_an       (o_an)
    );

    rgb_breather #(
        .PWM_BITS (PWM_BITS)
    ) u_rgb_breather (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .i_status   (i_status),
        .o_rgb      (o_rgb)
    );

endmodule

// File: tests/status_panel_sva.sv
/*
 * status panel assertions
 * one-hot anode scan and RGB dark before init, bound into scanner and RGB driver
 */
`timescale 1ns/1ps

module status_panel_sva #(
    parameter bit CHECK_AN  = 1'b1,
    parameter bit CHECK_RGB = 1'b1
) (
    input logic                     CORE_CLK,
    input logic                     CORE_RST_X,
    input panel_pkg::panel_status_t i_status,
    input logic [7:0]               i_an,
    input logic [2:0]               i_rgb
);
    if (CHECK_AN) begin : g_an
        logic r_an_seen;  // first scan step taken

        always_ff @(posedge CORE_CLK) begin
            if (!CORE_RST_X)
                r_an_seen <= 1'b0;
            else if (i_an != 8'hff)
                r_an_seen <= 1'b1;
        end

        a_an_onehot: assert property (@(posedge CORE_CLK) disable iff (!CORE_RST_X)
            r_an_seen |-> $onehot(~i_an))
            else $error("anode pattern does not select exactly one digit");
    end

    if (CHECK_RGB) begin : g_rgb
        // output is registered, so it follows the status one cycle later
        a_rgb_dark: assert property (@(posedge CORE_CLK) disable iff (!CORE_RST_X)
            (!i_status.loading && !i_status.init_done) |=> (i_rgb == 3'b000))
            else $error("RGB LED lit while neither loading nor initialised");
    end

endmodule

bind seg7_scanner status_panel_sva #(.CHECK_AN(1'b1), .CHECK_RGB(1'b0)) u_sva (
    .CORE_CLK   (CORE_CLK),
    .CORE_RST_X (CORE_RST_X),
    .i_status   (i_status),
    .i_an       (o_an),
    .i_rgb      (3'b000)
);

bind rgb_breather status_panel_sva #(.CHECK_AN(1'b0), .CHECK_RGB(1'b1)) u_sva (
    .CORE_CLK   (CORE_CLK),
    .CORE_RST_X (CORE_RST_X),
    .i_status   (i_status),
    .i_an       (8'hfe),
    .i_rgb      (o_rgb)
);

// File: tests/status_panel_tb.sv
/*
 * status panel testbench
 * random stimulus against a reference model of history, select, glyphs and LEDs
 */
`timescale 1ns/1ps

module status_panel_tb;
    import panel_pkg::*;

    localparam int HB_HALF   = 50;
    localparam int SCAN      = 8;
    localparam int LSTEP     = 6;
    localparam int PWM       = 6;
    localparam int AN_WAIT   = 4 * SCAN;  // cycles allowed per digit step

    logic          CORE_CLK;
    logic          CORE_RST_X;
    panel_status_t i_status;
    buttons_t      i_buttons;
    byte_event_t   i_kbd;
    byte_event_t   i_mouse;
    logic [31:0]   i_core_pc;
    logic [31:0]   i_core_ir;
    logic [15:0]   o_led;
    logic [7:0]    o_sg;
    logic [7:0]    o_an;
    logic [2:0]    o_rgb;

    int          checks;
    int          errs;
    int          total_checks;
    int          total_errs;
    logic [7:0]  last_an;
    logic [15:0] kbd_hist;    // model, older byte high
    logic [15:0] mouse_hist;
    int          load_cycles;

    status_panel_top #(
        .HEARTBEAT_HALF (HB_HALF),
        .SCAN_DIV       (SCAN),
        .LOAD_STEP_BITS (LSTEP),
        .PWM_BITS       (PWM)
    ) u_status_panel_top (.*);

    initial begin
        CORE_CLK = 1'b0;
        forever #10 CORE_CLK = ~CORE_CLK;
    end

    // loading cycles as seen by the scanner
    always @(posedge CORE_CLK) begin
        if (CORE_RST_X && i_status.loading)
            load_cycles++;
    end

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (exp === act)
        else begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic finish_test(string name);
        $display("test %s: %0d checks, %0d errors", name, checks, errs);
        total_checks += checks;
        total_errs   += errs;
        checks = 0;
        errs   = 0;
    endtask

    task automatic drive_edge();
        @(posedge CORE_CLK);
        #2;
    endtask

    // waits for the next digit step, returns its index or -1
    task automatic next_digit(output int d);
        int n;
        int lows;
        d = -1;
        n = 0;
        lows = 0;
        while (o_an == last_an && n < AN_WAIT) begin
            @(negedge CORE_CLK);
            n++;
        end
        if (o_an == last_an) begin
            $display("Timeout: anode pattern did not advance");
            errs++;
            return;
        end
        last_an = o_an;
        for (int i = 0; i < 8; i++) begin
            if (!o_an[i]) begin
                lows++;
                d = i;
            end
        end
        assert (lows == 1)
        else begin
            $display("Anode pattern %h does not select exactly one digit", o_an);
            errs++;
            d = -1;
        end
    endtask

    task automatic skip_digits(int count);
        int d;
        repeat (count) next_digit(d);
    endtask

    // mode 0 banner, mode 1 hex of value
    task automatic check_digits(string name, int mode, logic [31:0] value);
        int     d;
        glyph_t exp;
        repeat (8) begin
            next_digit(d);
            if (d >= 0) begin
                exp = (mode == 0) ? BANNER_GLYPHS[d] : HEX_GLYPHS[value[4*d +: 4]];
                check_value(name, {24'd0, ~exp}, {24'd0, o_sg});
            end
        end
    endtask

    task automatic send_events(int cycles);
        repeat (cycles) begin
            drive_edge();
            i_kbd   = {($urandom % 3) == 0, 8'($urandom)};
            i_mouse = {($urandom % 4) == 0, 8'($urandom)};
            if (i_kbd.valid)
                kbd_hist = {kbd_hist[7:0], i_kbd.data};
            if (i_mouse.valid)
                mouse_hist = {mouse_hist[7:0], i_mouse.data};
        end
        drive_edge();
        i_kbd   = '0;
        i_mouse = '0;
    endtask

    // cycles until o_led[0] next changes, -1 on timeout
    task automatic toggle_interval(output int cycles);
        logic prev;
        prev = o_led[0];
        cycles = 0;
        while (o_led[0] == prev && cycles < 4 * HB_HALF) begin
            @(negedge CORE_CLK);
            cycles++;
        end
        if (o_led[0] == prev) begin
            $display("Timeout: heartbeat LED stopped toggling");
            errs++;
            cycles = -1;
        end
    endtask

    initial begin
        int          d;
        int          on_cnt;
        int          n;
        logic [1:0]  pv;
        logic [2:0]  colour;
        logic [31:0] exp_val;

        void'($urandom(32'h4581));
        CORE_RST_X = 1'b0;
        i_status   = '0;
        i_buttons  = '0;
        i_kbd      = '0;
        i_mouse    = '0;
        i_core_pc  = '0;
        i_core_ir  = '0;
        checks = 0;
        errs = 0;
        total_checks = 0;
        total_errs = 0;
        last_an = 8'hff;
        kbd_hist = '0;
        mouse_hist = '0;
        load_cycles = 0;
        repeat (4) @(posedge CORE_CLK);
        #2 CORE_RST_X = 1'b1;

        // banner before init
        skip_digits(8);
        check_digits("banner", 0, 32'd0);
        repeat (32) begin
            @(negedge CORE_CLK);
            check_value("banner_rgb", 32'd0, {29'd0, o_rgb});
        end
        finish_test("banner");

        drive_edge();
        i_status.init_done = 1'b1;
        for (int r = 0; r < 6; r++) begin
            send_events(20);
            skip_digits(16);  // two full scan rounds
            check_digits("history", 1, {mouse_hist, kbd_hist});
        end
        finish_test("history");

        for (int r = 0; r < 12; r++) begin
            drive_edge();
            i_buttons = buttons_t'(($urandom % 4 == 0) ? 5'd0 : 5'($urandom));
            i_core_pc = $urandom;
            i_core_ir = $urandom;
            if (i_buttons.up || i_buttons.down || i_buttons.center)
                exp_val = '0;
            else if (i_buttons.left)
                exp_val = i_core_pc;
            else if (i_buttons.right)
                exp_val = i_core_ir;
            else
                exp_val = {mouse_hist, kbd_hist};
            skip_digits(8);
            check_digits("button_select", 1, exp_val);
        end
        drive_edge();
        i_buttons = '0;
        finish_test("button_select");

        drive_edge();
        i_status.loading = 1'b1;
        skip_digits(2);
        repeat (96) begin
            next_digit(d);
            if (d >= 0) begin
                n = ((load_cycles - 1) >> LSTEP) & 15;  // step before this scan edge
                check_value("loading", {24'd0, ~LOAD_GLYPHS[(n + 7 - d) & 15]},
                            {24'd0, o_sg});
            end
        end
        drive_edge();
        i_status.loading = 1'b0;
        finish_test("loading");

        for (int r = 0; r < 8; r++) begin
            drive_edge();
            case ($urandom % 3)
                0:       pv = PRIV_U;
                1:       pv = PRIV_S;
                default: pv = PRIV_M;
            endcase
            i_status.priv = pv;
            colour = (pv == PRIV_U) ? RGB_BLUE : (pv == PRIV_S) ? RGB_GREEN : RGB_RED;
            repeat (2) @(negedge CORE_CLK);  // one cycle of output latency
            on_cnt = 0;
            repeat (64) begin
                @(negedge CORE_CLK);
                if (o_rgb != RGB_OFF) begin
                    on_cnt++;
                    check_value("priv_colour", {29'd0, colour}, {29'd0, o_rgb});
                end
            end
            check_value("priv_on_count", 32'd4, on_cnt);
        end
        finish_test("priv_colour");

        for (int r = 0; r < 4; r++) begin
            drive_edge();
            i_status.init_done = 1'($urandom);
            i_status.loading   = 1'($urandom);
            toggle_interval(n);
            toggle_interval(n);
            check_value("heartbeat_period", HB_HALF, n);
            check_value("status_leds", {29'd0, i_status.loading, i_status.init_done},
                        {16'd0, o_led[15:1]});
        end
        finish_test("heartbeat_leds");

        $display("total: %0d checks, %0d errors", total_checks, total_errs);
        if (total_errs == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: build.f
hw/panel_pkg.sv
hw/status_capture.sv
hw/seg7_scanner.sv
hw/rgb_breather.sv
hw/status_panel_top.sv
tests/status_panel_sva.sv
tests/status_panel_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the status panel testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module status_panel_tb -o status_panel_sim \
    && ./obj_dir/status_panel_sim | tee /dev/stderr | grep -q "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
